/* Bender.yml */
package:
  name: mmu

sources:
  - rtl/mmu_pkg.sv
  - rtl/tlb_entry_array.sv
  - rtl/tlb_lookup.sv
  - rtl/mmu_translate.sv
  - rtl/mmu_top.sv
  - target: simulation
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_mmu.sv

/* mmu.f */
rtl/mmu_pkg.sv
rtl/tlb_entry_array.sv
rtl/tlb_lookup.sv
rtl/mmu_translate.sv
rtl/mmu_top.sv
tb/tb_clock_gen.sv
tb/tb_mmu.sv

/* rtl/mmu_pkg.sv */
/* Widths, TLB entry layout, address fields and fault codes for the MMU.
   Every RTL module takes these with a wildcard import. */
package mmu_pkg;

    localparam int ADDR_W      = 32;
    localparam int ASID_W      = 8;
    localparam int INDEX_W     = 4;
    localparam int TLB_ENTRIES = 2 ** INDEX_W;
    localparam int PFN_W       = 24;
    localparam int PPN_W       = 20;    // PFN bits that reach the 32-bit physical address.
    localparam int VPN2_W      = 19;
    localparam int ENTRY_LO_W  = 26;
    localparam int ENTRY_W     = 80;

    // Field positions inside one TLB entry.
    localparam int ASID_HI = 79;
    localparam int ASID_LO = 72;
    localparam int G_BIT   = 71;
    localparam int VPN2_HI = 70;
    localparam int VPN2_LO = 52;
    localparam int PFN1_HI = 51;
    localparam int PFN1_LO = 28;
    localparam int D1_BIT  = 27;
    localparam int V1_BIT  = 26;
    localparam int PFN0_HI = 25;
    localparam int PFN0_LO = 2;
    localparam int D0_BIT  = 1;
    localparam int V0_BIT  = 0;

    localparam int VA_VPN2_LO    = 13;
    localparam int VA_ODD_BIT    = 12;  // Picks the odd page of the pair.
    localparam int PAGE_OFFSET_W = 12;

    typedef logic [ADDR_W-1:0]     vaddr_t;
    typedef logic [ADDR_W-1:0]     paddr_t;
    typedef logic [ASID_W-1:0]     asid_t;
    typedef logic [INDEX_W-1:0]    tlb_index_t;
    typedef logic [PFN_W-1:0]      pfn_t;
    typedef logic [VPN2_W-1:0]     vpn2_t;
    typedef logic [ENTRY_LO_W-1:0] entry_lo_t;    // {PFN, D, V}.
    typedef logic [ENTRY_W-1:0]    tlb_entry_t;

    typedef enum logic [1:0] {
        FAULT_NONE,
        FAULT_REFILL,       // No matching entry.
        FAULT_INVALID,      // Selected page has V clear.
        FAULT_MODIFIED      // Store to a page with D clear.
    } mmu_fault_t;

endpackage

/* rtl/mmu_top.sv */
/* MMU top level with the entry array, instruction, data and probe lookups and two ports.
   Entry-hi/entry-lo values and write strobes come straight from the CP0 side. */
`timescale 1ns/100ps

module mmu_top import mmu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        i_req,
    input  vaddr_t      i_vaddr,
    input  logic        d_req,
    input  vaddr_t      d_vaddr,
    input  logic        d_store,
    input  asid_t       asid,
    input  vaddr_t      entry_hi,
    input  entry_lo_t   entry_lo0,
    input  entry_lo_t   entry_lo1,
    input  logic        entry_global,
    input  logic        write_indexed,
    input  logic        write_random,
    input  tlb_index_t  write_index,
    input  logic        probe,
    output logic        i_done,
    output paddr_t      i_paddr,
    output mmu_fault_t  i_fault,
    output logic        d_done,
    output paddr_t      d_paddr,
    output mmu_fault_t  d_fault,
    output logic        probe_done,
    output logic        probe_miss,
    output tlb_index_t  probe_index,
    output tlb_index_t  random_index
);

    tlb_entry_t [TLB_ENTRIES-1:0] entries;

    logic       i_hit, i_dirty, i_valid;
    pfn_t       i_pfn;
    logic       d_hit, d_dirty, d_valid;
    pfn_t       d_pfn;
    logic       p_hit;
    tlb_index_t p_index;

    tlb_entry_array array_i (
        .clk           (clk),
        .reset         (reset),
        .entry_hi      (entry_hi),
        .entry_lo0     (entry_lo0),
        .entry_lo1     (entry_lo1),
        .entry_global  (entry_global),
        .asid          (asid),
        .write_indexed (write_indexed),
        .write_random  (write_random),
        .write_index   (write_index),
        .probe         (probe),
        .probe_hit     (p_hit),
        .probe_match   (p_index),
        .entries       (entries),
        .random_index  (random_index),
        .probe_done    (probe_done),
        .probe_miss    (probe_miss),
        .probe_index   (probe_index)
    );

    tlb_lookup i_lookup_i (
        .entries (entries),
        .vaddr   (i_vaddr),
        .asid    (asid),
        .hit     (i_hit),
        .index   (),
        .pfn     (i_pfn),
        .dirty   (i_dirty),
        .valid   (i_valid)
    );

    tlb_lookup d_lookup_i (
        .entries (entries),
        .vaddr   (d_vaddr),
        .asid    (asid),
        .hit     (d_hit),
        .index   (),
        .pfn     (d_pfn),
        .dirty   (d_dirty),
        .valid   (d_valid)
    );

    tlb_lookup p_lookup_i (
        .entries (entries),
        .vaddr   (entry_hi),
        .asid    (asid),
        .hit     (p_hit),
        .index   (p_index),
        .pfn     (),
        .dirty   (),
        .valid   ()
    );

    mmu_translate i_xlate_i (
        .clk   (clk),
        .reset (reset),
        .req   (i_req),
        .vaddr (i_vaddr),
        .store (1'b0),      // Fetches never store.
        .hit   (i_hit),
        .pfn   (i_pfn),
        .dirty (i_dirty),
        .valid (i_valid),
        .done  (i_done),
        .paddr (i_paddr),
        .fault (i_fault)
    );

    mmu_translate d_xlate_i (
        .clk   (clk),
        .reset (reset),
        .req   (d_req),
        .vaddr (d_vaddr),
        .store (d_store),
        .hit   (d_hit),
        .pfn   (d_pfn),
        .dirty (d_dirty),
        .valid (d_valid),
        .done  (d_done),
        .paddr (d_paddr),
        .fault (d_fault)
    );

endmodule

/* rtl/mmu_translate.sv */
/* One registered translation port: kseg0/kseg1 bypass, TLB address build and fault code.
   Results appear for one cycle after the request strobe. */
`timescale 1ns/100ps

module mmu_translate import mmu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        req,
    input  vaddr_t      vaddr,
    input  logic        store,
    input  logic        hit,
    input  pfn_t        pfn,
    input  logic        dirty,
    input  logic        valid,
    output logic        done,
    output paddr_t      paddr,
    output mmu_fault_t  fault
);

    logic       unmapped;
    paddr_t     next_paddr;
    mmu_fault_t next_fault;

    assign unmapped = (vaddr[ADDR_W-1:ADDR_W-2] == 2'b10);    // 0x8000_0000 to 0xBFFF_FFFF.

    always_comb begin
        if (unmapped) begin
            next_paddr = {3'b000, vaddr[ADDR_W-4:0]};
            next_fault = FAULT_NONE;
        end else begin
            next_paddr = {pfn[PPN_W-1:0], vaddr[PAGE_OFFSET_W-1:0]};
            if (!hit) begin
                next_fault = FAULT_REFILL;
            end else if (!valid) begin
                next_fault = FAULT_INVALID;
            end else if (store && !dirty) begin
                next_fault = FAULT_MODIFIED;
            end else begin
                next_fault = FAULT_NONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done  <= 1'b0;
            fault <= FAULT_NONE;
        end else begin
            done  <= req;
            fault <= req ? next_fault : FAULT_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            paddr <= next_paddr;
        end
    end

    idle_no_fault: assert property (@(posedge clk) disable iff (reset)
        !done |-> fault == FAULT_NONE);

endmodule

/* rtl/tlb_entry_array.sv */
/* Holds the TLB entries, the random replacement counter and the probe result.
   Entries are written from the entry-hi/entry-lo inputs on an indexed or random strobe. */
`timescale 1ns/100ps

module tlb_entry_array import mmu_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  vaddr_t                           entry_hi,
    input  entry_lo_t                        entry_lo0,
    input  entry_lo_t                        entry_lo1,
    input  logic                             entry_global,
    input  asid_t                            asid,
    input  logic                             write_indexed,
    input  logic                             write_random,
    input  tlb_index_t                       write_index,
    input  logic                             probe,
    input  logic                             probe_hit,
    input  tlb_index_t                       probe_match,
    output tlb_entry_t [TLB_ENTRIES-1:0]     entries,
    output tlb_index_t                       random_index,
    output logic                             probe_done,
    output logic                             probe_miss,
    output tlb_index_t                       probe_index
);

    tlb_entry_t new_entry;
    tlb_index_t write_sel;
    logic       write_en;

    always_comb begin
        new_entry[ASID_HI:ASID_LO] = asid;
        new_entry[G_BIT]           = entry_global;
        new_entry[VPN2_HI:VPN2_LO] = entry_hi[ADDR_W-1:VA_VPN2_LO];
        new_entry[PFN1_HI:V1_BIT]  = entry_lo1;
        new_entry[PFN0_HI:V0_BIT]  = entry_lo0;
    end

    assign write_en  = write_indexed || write_random;
    assign write_sel = write_indexed ? write_index : random_index;   // Indexed wins.

    always_ff @(posedge clk) begin
        if (reset) begin
            entries      <= '0;
            random_index <= tlb_index_t'(TLB_ENTRIES - 1);
        end else begin
            random_index <= random_index - 1'b1;    // Wraps 0 to 15.
            if (write_en) begin
                entries[write_sel] <= new_entry;
            end
        end
    end

    // Probe lookup runs on the current contents, so a same-cycle write is not seen.
    always_ff @(posedge clk) begin
        if (reset) begin
            probe_done <= 1'b0;
        end else begin
            probe_done <= probe;
        end
    end

    always_ff @(posedge clk) begin
        if (probe) begin
            probe_miss  <= !probe_hit;
            probe_index <= probe_match;
        end
    end

    random_countdown: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> random_index == tlb_index_t'($past(random_index) - 1'b1));

    probe_done_source: assert property (@(posedge clk) disable iff (reset)
        probe_done |-> $past(probe));

endmodule

/* rtl/tlb_lookup.sv */
/* Fully associative TLB match with lowest-index priority and even/odd page select.
   Purely combinational; one instance per translation port and one for the probe. */
`timescale 1ns/100ps

module tlb_lookup import mmu_pkg::*; (
    input  tlb_entry_t [TLB_ENTRIES-1:0] entries,
    input  vaddr_t                       vaddr,
    input  asid_t                        asid,
    output logic                         hit,
    output tlb_index_t                   index,
    output pfn_t                         pfn,
    output logic                         dirty,
    output logic                         valid
);

    logic [TLB_ENTRIES-1:0] matched;
    vpn2_t                  va_vpn2;
    tlb_entry_t             sel_entry;
    logic                   odd_page;

    assign va_vpn2  = vaddr[ADDR_W-1:VA_VPN2_LO];
    assign odd_page = vaddr[VA_ODD_BIT];

    // VPN2 must agree; ASID must agree unless the entry is global.
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            matched[i] = (entries[i][VPN2_HI:VPN2_LO] == va_vpn2) &&
                         ((entries[i][ASID_HI:ASID_LO] == asid) || entries[i][G_BIT]);
        end
    end

    // Scan from the top so the lowest matching index is the one left standing.
    always_comb begin
        index = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (matched[i]) begin
                index = tlb_index_t'(i);
            end
        end
    end

    assign hit       = |matched;
    assign sel_entry = entries[index];

    always_comb begin
        if (odd_page) begin
            pfn   = sel_entry[PFN1_HI:PFN1_LO];
            dirty = sel_entry[D1_BIT];
            valid = sel_entry[V1_BIT];
        end else begin
            pfn   = sel_entry[PFN0_HI:PFN0_LO];
            dirty = sel_entry[D0_BIT];
            valid = sel_entry[V0_BIT];
        end
    end

endmodule

/* tb/tb_clock_gen.sv */
/* Testbench clock and reset source for the MMU.
   100 ns clock; reset is held high for the first 3 rising edges. */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #10 reset = 1'b0;    // Released with the other inputs, after the edge.
    end

endmodule

/* tb/tb_mmu.sv */
/* Testbench for the MMU. It drives TLB writes, translations and probes and checks
   every result against a shadow TLB model with concurrent assertions. */
`timescale 1ns/100ps

module tb_mmu import mmu_pkg::*; ();

    localparam int RANDOM_OPS = 300;
    localparam int TOTAL_OPS  = RANDOM_OPS + 100;

    logic        clk, reset;
    logic        i_req, d_req, d_store, entry_global;
    logic        write_indexed, write_random, probe;
    vaddr_t      i_vaddr, d_vaddr, entry_hi;
    asid_t       asid;
    entry_lo_t   entry_lo0, entry_lo1;
    tlb_index_t  write_index;
    logic        i_done, d_done, probe_done, probe_miss;
    paddr_t      i_paddr, d_paddr;
    mmu_fault_t  i_fault, d_fault;
    tlb_index_t  probe_index, random_index;

    // Shadow TLB with one array per field.
    logic [18:0] sh_vpn2 [16];
    logic [7:0]  sh_asid [16];
    logic        sh_g    [16];
    logic [25:0] sh_lo0  [16];
    logic [25:0] sh_lo1  [16];
    logic [3:0]  sh_rand;
    logic [3:0]  widx;
    int          hit_at;

    logic        exp_i_done, exp_d_done, exp_p_done, exp_p_miss;
    logic [1:0]  exp_i_fault, exp_d_fault;
    logic [31:0] exp_i_paddr, exp_d_paddr;
    logic [3:0]  exp_p_index;

    logic [31:0] lfsr_state = 32'h5c0f_0c11;
    logic [18:0] vpn_list [16];
    int          n_vpn, errors, n_xlate, n_probe;
    asid_t       cur_asid;

    tb_clock_gen clock_i (.clk, .reset);

    mmu_top dut_i (.*);

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'hd000_0001 : lfsr_state >> 1;
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [18:0] new_vpn2();
        return {1'b0, 18'(rand_bits(18))};    // Keeps the pair in mapped space.
    endfunction

    function automatic vaddr_t pick_mapped();
        logic [31:0] sel;
        sel = rand_bits(4) % n_vpn;
        return {vpn_list[sel[3:0]], 13'(rand_bits(13))};
    endfunction

    // Lowest matching shadow entry or -1 when none matches.
    function automatic int find_entry(input vaddr_t va, input asid_t as);
        int k;
        k = -1;
        for (int e = 0; e < 16; e++) begin
            if (k < 0 && sh_vpn2[e] == va[31:13] && (sh_g[e] || sh_asid[e] == as)) begin
                k = e;
            end
        end
        return k;
    endfunction

    // Expected {fault, paddr} of one translation.
    function automatic logic [33:0] expect_xlate(input vaddr_t va, input asid_t as,
                                                 input logic st);
        int          k;
        logic [25:0] lo;
        logic [1:0]  f;
        k = find_entry(va, as);
        if (va[31:30] == 2'b10) begin
            return {2'(FAULT_NONE), 3'b000, va[28:0]};
        end
        if (k < 0) begin
            return {2'(FAULT_REFILL), 32'h0};
        end
        lo = va[12] ? sh_lo1[k] : sh_lo0[k];
        if (!lo[0]) begin
            f = FAULT_INVALID;
        end else if (st && !lo[1]) begin
            f = FAULT_MODIFIED;
        end else begin
            f = FAULT_NONE;
        end
        return {f, lo[21:2], va[11:0]};
    endfunction

    always @(posedge clk) begin
        exp_i_done <= !reset && i_req;
        exp_d_done <= !reset && d_req;
        exp_p_done <= !reset && probe;
        if (i_req) begin
            {exp_i_fault, exp_i_paddr} <= expect_xlate(i_vaddr, asid, 1'b0);
        end
        if (d_req) begin
            {exp_d_fault, exp_d_paddr} <= expect_xlate(d_vaddr, asid, d_store);
        end
        if (probe) begin
            hit_at = find_entry(entry_hi, asid);
            exp_p_miss  <= (hit_at < 0);
            exp_p_index <= 4'(hit_at);
        end
        if (reset) begin
            sh_rand <= 4'd15;
            for (int e = 0; e < 16; e++) begin
                {sh_vpn2[e], sh_asid[e], sh_g[e], sh_lo0[e], sh_lo1[e]} <= '0;
            end
        end else begin
            sh_rand <= sh_rand - 4'd1;
            if (write_indexed || write_random) begin
                widx = write_indexed ? write_index : sh_rand;
                sh_vpn2[widx] <= entry_hi[31:13];
                sh_asid[widx] <= asid;
                sh_g[widx]    <= entry_global;
                sh_lo0[widx]  <= entry_lo0;
                sh_lo1[widx]  <= entry_lo1;
            end
        end
    end

    always @(posedge clk) begin
        n_xlate <= n_xlate + int'(i_done) + int'(d_done);
        n_probe <= n_probe + int'(probe_done);
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        errors++;
        $display("Fail %s expected %h got %h at %0t", name, exp_val, act_val, $time);
    endtask

    rand_check: assert property (@(posedge clk) disable iff (reset) random_index == sh_rand)
        else report_mismatch("random_index", $sampled(sh_rand), $sampled(random_index));
    i_done_check: assert property (@(posedge clk) disable iff (reset) i_done == exp_i_done)
        else report_mismatch("i_done", $sampled(exp_i_done), $sampled(i_done));
    i_fault_check: assert property (@(posedge clk) disable iff (reset)
        i_done |-> i_fault == exp_i_fault)
        else report_mismatch("i_fault", $sampled(exp_i_fault), $sampled(i_fault));
    i_paddr_check: assert property (@(posedge clk) disable iff (reset)
        i_done && exp_i_fault != FAULT_REFILL |-> i_paddr == exp_i_paddr)
        else report_mismatch("i_paddr", $sampled(exp_i_paddr), $sampled(i_paddr));
    d_done_check: assert property (@(posedge clk) disable iff (reset) d_done == exp_d_done)
        else report_mismatch("d_done", $sampled(exp_d_done), $sampled(d_done));
    d_fault_check: assert property (@(posedge clk) disable iff (reset)
        d_done |-> d_fault == exp_d_fault)
        else report_mismatch("d_fault", $sampled(exp_d_fault), $sampled(d_fault));
    d_paddr_check: assert property (@(posedge clk) disable iff (reset)
        d_done && exp_d_fault != FAULT_REFILL |-> d_paddr == exp_d_paddr)
        else report_mismatch("d_paddr", $sampled(exp_d_paddr), $sampled(d_paddr));
    p_done_check: assert property (@(posedge clk) disable iff (reset) probe_done == exp_p_done)
        else report_mismatch("probe_done", $sampled(exp_p_done), $sampled(probe_done));
    p_miss_check: assert property (@(posedge clk) disable iff (reset)
        probe_done |-> probe_miss == exp_p_miss)
        else report_mismatch("probe_miss", $sampled(exp_p_miss), $sampled(probe_miss));
    p_index_check: assert property (@(posedge clk) disable iff (reset)
        probe_done && !exp_p_miss |-> probe_index == exp_p_index)
        else report_mismatch("probe_index", $sampled(exp_p_index), $sampled(probe_index));

    // Strobes last exactly one edge.
    task automatic next_cycle();
        @(posedge clk);
        #10;
        {i_req, d_req, d_store, write_indexed, write_random, probe} = '0;
    endtask

    task automatic write_entry(input logic rnd, input logic [3:0] idx, input logic [18:0] vpn2,
                               input logic g, input logic [25:0] lo0, input logic [25:0] lo1);
        entry_hi        = {vpn2, 13'h0};
        asid            = cur_asid;
        entry_global    = g;
        entry_lo0       = lo0;
        entry_lo1       = lo1;
        write_index     = idx;
        write_indexed   = !rnd;
        write_random    = rnd;
        vpn_list[n_vpn] = vpn2;
        n_vpn++;
        next_cycle();
    endtask

    task automatic translate(input vaddr_t iva, input vaddr_t dva, input logic st,
                             input asid_t as);
        i_vaddr = iva;
        d_vaddr = dva;
        d_store = st;
        asid    = as;
        i_req   = 1'b1;
        d_req   = 1'b1;
        next_cycle();
    endtask

    task automatic probe_for(input logic [18:0] vpn2, input asid_t as);
        entry_hi = {vpn2, 13'h0};
        asid     = as;
        probe    = 1'b1;
        next_cycle();
    endtask

    initial begin
        {i_req, d_req, d_store, write_indexed, write_random, probe, entry_global} = '0;
        i_vaddr     = '0;
        d_vaddr     = '0;
        entry_hi    = '0;
        entry_lo0   = '0;
        entry_lo1   = '0;
        write_index = '0;
        asid        = '0;
        cur_asid    = 8'h3a;
        n_vpn       = 0;
        @(negedge reset);
        repeat (20) next_cycle();    // Idle long enough for the counter to wrap.

        for (int k = 0; k < 6; k++) begin
            write_entry(1'b0, 4'(k), new_vpn2(), k == 5, {24'(rand_bits(24)), 2'b11},
                        {24'(rand_bits(24)), 2'b11});
        end
        write_entry(1'b0, 4'd6, new_vpn2(), 1'b0, {24'(rand_bits(24)), 2'b10},
                    {24'(rand_bits(24)), 2'b01});    // Even page invalid, odd page clean.
        write_entry(1'b0, 4'd7, vpn_list[2], 1'b0, {24'(rand_bits(24)), 2'b11},
                    {24'(rand_bits(24)), 2'b11});    // Shadowed by entry 2.
        while (sh_rand < 4'd11) next_cycle();    // Random writes land above entry 7.
        repeat (3) begin
            write_entry(1'b1, 4'd0, new_vpn2(), 1'b0, {24'(rand_bits(24)), 2'b11},
                        {24'(rand_bits(24)), 2'b01});
        end

        for (int k = 0; k < n_vpn; k++) begin
            translate({vpn_list[k], 1'b0, 12'(rand_bits(12))},
                      {vpn_list[k], 1'b1, 12'(rand_bits(12))}, 1'b0, cur_asid);
        end
        translate({vpn_list[6], 13'h0123}, {vpn_list[6], 13'h1456}, 1'b1, cur_asid);
        translate({vpn_list[6], 13'h0789}, {vpn_list[6], 13'h0abc}, 1'b1, cur_asid);
        for (int k = 0; k < n_vpn; k++) begin
            translate({vpn_list[k], 13'(rand_bits(13))}, {vpn_list[k], 13'(rand_bits(13))},
                      1'b0, cur_asid ^ 8'hff);    // Only the global entry hits.
        end
        repeat (4) begin
            translate({3'b100, 29'(rand_bits(29))}, {3'b101, 29'(rand_bits(29))},
                      1'(rand_bits(1)), cur_asid);
        end
        for (int k = 0; k < n_vpn; k++) begin
            probe_for(vpn_list[k], cur_asid);
        end
        probe_for(new_vpn2(), cur_asid);
        probe_for(vpn_list[0], cur_asid ^ 8'hff);

        repeat (RANDOM_OPS) begin
            if (rand_bits(2) == 0) begin
                probe_for(rand_bits(1) ? new_vpn2() : 19'(pick_mapped() >> 13), cur_asid);
            end else begin
                translate(pick_mapped(), rand_bits(1) ? rand_bits(32) : pick_mapped(),
                          1'(rand_bits(1)), rand_bits(3) == 0 ? cur_asid ^ 8'hff : cur_asid);
            end
        end
        repeat (3) next_cycle();

        $display("Checked %0d translations and %0d probes, %0d errors",
                 n_xlate, n_probe, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #((TOTAL_OPS + 100) * 100);
        $display("Run timed out before the test sequence finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule
